// ==== adpll_pkg.sv ====
`default_nettype none

package adpll_pkg;

  // ----------------------------------------------------------------------
  // delay code
  localparam int DELAY_W = 7;
  typedef logic [DELAY_W-1:0] delay_t;

  localparam delay_t DELAY_RESET = 7'd64;          // mid-range after reset
  localparam delay_t DELAY_MAX   = 7'd127;         // clamp top, bottom is 0

  // ring geometry
  localparam int NUM_TAPS  = 32;
  localparam int TAP_DEPTH = 4;                    // cycles per active tap
  localparam int FINE_W    = 2;                    // code bits 1..0
  localparam int DIV_RATIO = 5;                    // gen periods per fbk period
  localparam int DIV_W     = $clog2(DIV_RATIO);

  // ----------------------------------------------------------------------
  // period measurement
  localparam int CNT_W = 12;
  typedef logic [CNT_W-1:0] cnt_t;                 // saturating counters

  localparam int MAG_W = 5;
  typedef logic [MAG_W-1:0] mag_t;                 // thermometer magnitude

  localparam cnt_t ERR_THRESH [MAG_W] = '{12'd10, 12'd20, 12'd40, 12'd80, 12'd160};
  localparam cnt_t COARSE_THRESH      = 12'd320;

  // loop filter steps, indexed by highest set magnitude bit
  localparam delay_t STEP_TABLE [MAG_W] = '{7'd1, 7'd2, 7'd3, 7'd5, 7'd9};
  localparam delay_t COARSE_STEP        = 7'd20;

  // lock detect
  localparam cnt_t LOCK_TOL   = 12'd9;             // largest error still counted as locked
  localparam int   LOCK_CNT   = 8;
  localparam int   LOCK_CNT_W = $clog2(LOCK_CNT + 1);

  typedef enum logic [1:0] {MEAS_WAIT, MEAS_PRIME, MEAS_RUN} meas_state_e;

  typedef enum logic [2:0] {
    ADJ_HOLD,
    ADJ_LOAD,
    ADJ_INC,
    ADJ_DEC,
    ADJ_COARSE_INC,
    ADJ_COARSE_DEC
  } adj_op_e;

endpackage

`default_nettype wire

// ==== adpll_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpll_top (
  input  wire                    CLKI_OSC,
  input  wire                    clk_fbk_f_rst,
  input  wire                    ref_clk_i,
  input  wire                    load_base_i,
  input  wire adpll_pkg::delay_t base_dly_i,
  output logic                   gen_clk_o,
  output logic                   lock_o,
  output adpll_pkg::delay_t      cur_delay_o
);
  import adpll_pkg::*;

  wire [NUM_TAPS:0]   ring;                        // tap chain, 0 = injection
  wire [NUM_TAPS-1:0] bypass;
  wire                ring_ret;
  wire                fbk_clk;

  pd_if pd ();

  // ----------------------------------------------------------------------
  // ring
  tap_ctrl u_tap_ctrl (
    .CLKI_OSC      (CLKI_OSC),
    .clk_fbk_f_rst (clk_fbk_f_rst),
    .delay_i       (cur_delay_o),
    .ring_ret_i    (ring_ret),
    .ring_o        (ring[0]),
    .bypass_o      (bypass)
  );

  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    delay_tap u_delay_tap (
      .CLKI_OSC      (CLKI_OSC),
      .clk_fbk_f_rst (clk_fbk_f_rst),
      .sig_i         (ring[k]),
      .bypass_i      (bypass[k]),
      .sig_o         (ring[k+1])
    );
  end

  ring_out u_ring_out (
    .CLKI_OSC      (CLKI_OSC),
    .clk_fbk_f_rst (clk_fbk_f_rst),
    .sig_i         (ring[NUM_TAPS]),
    .fine_i        (cur_delay_o[FINE_W-1:0]),
    .ring_ret_o    (ring_ret),
    .gen_clk_o     (gen_clk_o),
    .fbk_clk_o     (fbk_clk)
  );

  // detector and filter close the loop
  freq_phase_det u_freq_phase_det (
    .CLKI_OSC      (CLKI_OSC),
    .clk_fbk_f_rst (clk_fbk_f_rst),
    .ref_clk_i     (ref_clk_i),
    .fbk_clk_i     (fbk_clk),
    .pd            (pd.det)
  );

  loop_filter u_loop_filter (
    .CLKI_OSC      (CLKI_OSC),
    .clk_fbk_f_rst (clk_fbk_f_rst),
    .load_base_i   (load_base_i),
    .base_dly_i    (base_dly_i),
    .pd            (pd.filt),
    .delay_o       (cur_delay_o),
    .lock_o        (lock_o)
  );

endmodule

`default_nettype wire

// ==== delay_tap.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_tap (
  input  wire  CLKI_OSC,
  input  wire  clk_fbk_f_rst,
  input  wire  sig_i,
  input  wire  bypass_i,                           // 1 = tap skipped
  output logic sig_o
);
  import adpll_pkg::*;

  logic [TAP_DEPTH-1:0] sh;                        // bit 0 is newest

  // ----------------------------------------------------------------------
  // shift runs even while bypassed
  // so a tap switched in already holds recent ring history
  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      sh <= '0;
    end else begin
      sh <= {sh[TAP_DEPTH-2:0], sig_i};
    end
  end

  assign sig_o = bypass_i ? sig_i : sh[TAP_DEPTH-1];   // TAP_DEPTH cycles when active

endmodule

`default_nettype wire

// ==== freq_phase_det.sv ====
`timescale 1ns/1ps
`default_nettype none

module freq_phase_det (
  input  wire  CLKI_OSC,
  input  wire  clk_fbk_f_rst,
  input  wire  ref_clk_i,                          // async to osc clock
  input  wire  fbk_clk_i,                          // already osc-synchronous
  pd_if.det    pd
);
  import adpll_pkg::*;

  logic                  ref_s1;
  logic                  ref_s2;
  logic                  ref_s3;                   // edge detect stage
  logic                  fbk_q;
  logic                  ref_rise;
  logic                  fbk_rise;
  logic                  take;                     // measurement this cycle
  logic [1:0]            fbk_fresh;                // fbk rises since last meas, sat 2
  meas_state_e           state;
  cnt_t                  ref_cnt;
  cnt_t                  fbk_cnt;
  cnt_t                  fbk_per;                  // last complete fbk period
  logic signed [CNT_W:0] err;
  cnt_t                  abs_err;
  mag_t                  mag;
  logic                  coarse;

  // ----------------------------------------------------------------------
  // synchronizer and edges
  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      ref_s1 <= 1'b0;
      ref_s2 <= 1'b0;
      ref_s3 <= 1'b0;
      fbk_q  <= 1'b0;
    end else begin
      ref_s1 <= ref_clk_i;
      ref_s2 <= ref_s1;
      ref_s3 <= ref_s2;
      fbk_q  <= fbk_clk_i;
    end
  end

  assign ref_rise = ref_s2 & ~ref_s3;
  assign fbk_rise = fbk_clk_i & ~fbk_q;
  // a whole fbk period after the last update, so the filter sees its own effect
  assign take     = ref_rise && (state != MEAS_WAIT) && (fbk_fresh == 2'd2);

  // feedback period counter
  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      fbk_cnt   <= '0;
      fbk_per   <= '0;
      fbk_fresh <= '0;
    end else begin
      if (fbk_rise) begin
        fbk_cnt <= cnt_t'(1);
        fbk_per <= fbk_cnt;
      end else if (~&fbk_cnt) begin
        fbk_cnt <= fbk_cnt + 1'b1;                 // saturate
      end
      if (take) fbk_fresh <= {1'b0, fbk_rise};
      else if (fbk_rise && (fbk_fresh != 2'd2)) fbk_fresh <= fbk_fresh + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // grade ref minus fbk, positive = osc too fast
  always_comb begin
    err     = $signed({1'b0, ref_cnt}) - $signed({1'b0, fbk_per});
    abs_err = err[CNT_W] ? cnt_t'(-err) : err[CNT_W-1:0];
    for (int k = 0; k < MAG_W; k++) begin
      mag[k] = (abs_err >= ERR_THRESH[k]);
    end
    coarse = (abs_err >= COARSE_THRESH);
  end

  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      state       <= MEAS_WAIT;
      ref_cnt     <= '0;
      pd.meas_vld <= 1'b0;
      pd.up_mag   <= '0;
      pd.dn_mag   <= '0;
      pd.too_fast <= 1'b0;
      pd.too_slow <= 1'b0;
    end else begin
      pd.meas_vld <= take;                         // 3 cycles after ref edge
      if (ref_rise) begin
        ref_cnt <= cnt_t'(1);
        state   <= (state == MEAS_WAIT) ? MEAS_PRIME : MEAS_RUN;
      end else if (~&ref_cnt) begin
        ref_cnt <= ref_cnt + 1'b1;
      end
      if (take) begin
        pd.up_mag   <= err[CNT_W] ? mag : '0;
        pd.dn_mag   <= err[CNT_W] ? '0 : mag;
        pd.too_fast <= coarse & ~err[CNT_W];
        pd.too_slow <= coarse & err[CNT_W];
      end
    end
  end

  assert property (@(posedge CLKI_OSC) disable iff (clk_fbk_f_rst)
    !((|pd.up_mag) && (|pd.dn_mag)));

endmodule

`default_nettype wire

// ==== loop_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_filter (
  input  wire                    CLKI_OSC,
  input  wire                    clk_fbk_f_rst,
  input  wire                    load_base_i,
  input  wire adpll_pkg::delay_t base_dly_i,
  pd_if.filt                     pd,
  output adpll_pkg::delay_t      delay_o,
  output logic                   lock_o
);
  import adpll_pkg::*;

  adj_op_e               op;
  mag_t                  mag;                      // whichever side is set
  delay_t                step;
  logic [DELAY_W:0]      sum;                      // one bit of headroom
  delay_t                delay_nxt;
  logic [LOCK_CNT_W-1:0] lock_cnt;

  assign mag = pd.up_mag | pd.dn_mag;

  // ----------------------------------------------------------------------
  // opcode, load wins over a measurement
  always_comb begin
    op = ADJ_HOLD;
    if (load_base_i) begin
      op = ADJ_LOAD;
    end else if (pd.meas_vld) begin
      if (pd.too_fast) op = ADJ_COARSE_INC;
      else if (pd.too_slow) op = ADJ_COARSE_DEC;
      else if (|pd.dn_mag) op = ADJ_INC;
      else if (|pd.up_mag) op = ADJ_DEC;
    end
  end

  // step from highest magnitude bit
  always_comb begin
    step = '0;
    for (int k = 0; k < MAG_W; k++) begin
      if (mag[k]) step = STEP_TABLE[k];
    end
    if ((op == ADJ_COARSE_INC) || (op == ADJ_COARSE_DEC)) step = COARSE_STEP;
  end

  // apply with clamp to 0..DELAY_MAX
  always_comb begin
    sum = {1'b0, delay_o} + {1'b0, step};
    case (op)
      ADJ_LOAD:                delay_nxt = base_dly_i;
      ADJ_INC, ADJ_COARSE_INC: delay_nxt = (sum > DELAY_MAX) ? DELAY_MAX : sum[DELAY_W-1:0];
      ADJ_DEC, ADJ_COARSE_DEC: delay_nxt = (delay_o < step) ? '0 : delay_o - step;
      default:                 delay_nxt = delay_o;
    endcase
  end

  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) delay_o <= DELAY_RESET;
    else delay_o <= delay_nxt;
  end

  // ----------------------------------------------------------------------
  // lock detect, consecutive small errors
  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      lock_cnt <= '0;
      lock_o   <= 1'b0;
    end else if (load_base_i) begin
      lock_cnt <= '0;                              // new code, start over
      lock_o   <= 1'b0;
    end else if (pd.meas_vld) begin
      if (|mag) begin
        lock_cnt <= '0;
        lock_o   <= 1'b0;
      end else begin
        if (lock_cnt != LOCK_CNT_W'(LOCK_CNT)) lock_cnt <= lock_cnt + 1'b1;
        if (lock_cnt >= LOCK_CNT_W'(LOCK_CNT - 1)) lock_o <= 1'b1;
      end
    end
  end

  assert property (@(posedge CLKI_OSC) disable iff (clk_fbk_f_rst)
    delay_o <= DELAY_MAX);

endmodule

`default_nettype wire

// ==== pd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one frequency-error measurement, detector -> loop filter
interface pd_if;
  import adpll_pkg::*;

  logic meas_vld;                                  // one-cycle pulse
  mag_t up_mag;                                    // osc too slow, delay must fall
  mag_t dn_mag;                                    // osc too fast, delay must rise
  logic too_fast;                                  // gross error, valid with meas_vld
  logic too_slow;

  // ----------------------------------------------------------------------
  modport det (
    output meas_vld, up_mag, dn_mag, too_fast, too_slow
  );

  modport filt (
    input  meas_vld, up_mag, dn_mag, too_fast, too_slow
  );

endinterface

`default_nettype wire

// ==== ring_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module ring_out (
  input  wire                              CLKI_OSC,
  input  wire                              clk_fbk_f_rst,
  input  wire                              sig_i,        // last coarse tap
  input  wire [adpll_pkg::FINE_W-1:0]      fine_i,       // code bits 1..0
  output logic                             ring_ret_o,
  output logic                             gen_clk_o,
  output logic                             fbk_clk_o
);
  import adpll_pkg::*;

  logic [(1<<FINE_W)-2:0] fine_sh;                 // 1..3 cycles late
  logic [(1<<FINE_W)-1:0] fine_taps;               // index = cycles of delay
  logic                   gen_q;
  logic                   gen_rise;
  logic [DIV_W-1:0]       div_cnt;

  // ----------------------------------------------------------------------
  // fine stage
  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      fine_sh <= '0;
    end else begin
      fine_sh <= {fine_sh[(1<<FINE_W)-3:0], sig_i};
    end
  end

  assign fine_taps  = {fine_sh, sig_i};
  assign gen_clk_o  = fine_taps[fine_i];           // 0 to 3 extra cycles
  assign ring_ret_o = gen_clk_o;                   // back to injection reg

  // ----------------------------------------------------------------------
  // divide by DIV_RATIO on gen rising edges
  assign gen_rise = gen_clk_o & ~gen_q;

  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      gen_q     <= 1'b0;
      div_cnt   <= '0;
      fbk_clk_o <= 1'b0;
    end else begin
      gen_q <= gen_clk_o;
      if (gen_rise) begin
        if (div_cnt == DIV_W'(DIV_RATIO - 1)) div_cnt <= '0;
        else div_cnt <= div_cnt + 1'b1;
        // high while the new count is 0 or 1, about 40 % duty
        fbk_clk_o <= (div_cnt == DIV_W'(DIV_RATIO - 1)) || (div_cnt == '0);
      end
    end
  end

  assert property (@(posedge CLKI_OSC) disable iff (clk_fbk_f_rst)
    div_cnt < DIV_W'(DIV_RATIO));

endmodule

`default_nettype wire

// ==== tap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_ctrl (
  input  wire                                CLKI_OSC,
  input  wire                                clk_fbk_f_rst,
  input  wire adpll_pkg::delay_t             delay_i,
  input  wire                                ring_ret_i,   // end of fine stage
  output logic                               ring_o,       // into tap 0
  output logic [adpll_pkg::NUM_TAPS-1:0]     bypass_o
);
  import adpll_pkg::*;

  logic [DELAY_W-FINE_W-1:0] coarse;                        // number of active taps
  logic [NUM_TAPS-1:0]       active;

  assign coarse = delay_i[DELAY_W-1:FINE_W];

  // thermometer mask, low taps active
  always_comb begin
    for (int k = 0; k < NUM_TAPS; k++) begin
      bypass_o[k] = (k >= int'(coarse));
    end
  end

  assign active = ~bypass_o;

  // injection register, closes the ring with an inversion
  always_ff @(posedge CLKI_OSC or posedge clk_fbk_f_rst) begin
    if (clk_fbk_f_rst) begin
      ring_o <= 1'b0;                                       // ring idles low
    end else begin
      ring_o <= ~ring_ret_i;
    end
  end

  // active set is one contiguous run from tap 0, sized by the coarse code
  assert property (@(posedge CLKI_OSC) disable iff (clk_fbk_f_rst)
    ($countones(active) == int'(coarse)) && ((active & (active + 1'b1)) == '0));

endmodule

`default_nettype wire

// ==== tb.f ====
adpll_pkg.sv
pd_if.sv
tap_ctrl.sv
delay_tap.sv
ring_out.sv
freq_phase_det.sv
loop_filter.sv
adpll_top.sv
tb_adpll.sv

// ==== tb_adpll.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_adpll;
  import adpll_pkg::*;

  logic        CLKI_OSC;
  logic        clk_fbk_f_rst;
  logic        ref_clk_i;
  logic        load_base_i;
  delay_t      base_dly_i;
  logic        gen_clk_o;
  logic        lock_o;
  delay_t      cur_delay_o;

  logic [31:0] rand_state;                         // lcg state
  int          ref_half;                           // ref half period in cycles, 0 = held low
  logic        mon_steps;                          // step monitor enable
  delay_t      prev_delay;

  adpll_top DUT (
    .CLKI_OSC      (CLKI_OSC),
    .clk_fbk_f_rst (clk_fbk_f_rst),
    .ref_clk_i     (ref_clk_i),
    .load_base_i   (load_base_i),
    .base_dly_i    (base_dly_i),
    .gen_clk_o     (gen_clk_o),
    .lock_o        (lock_o),
    .cur_delay_o   (cur_delay_o)
  );

  // ----------------------------------------------------------------------
  // clock, 10 ns
  initial begin
    CLKI_OSC = 1'b0;
    forever #5 CLKI_OSC = ~CLKI_OSC;
  end

  // ref generator, toggles every ref_half cycles
  initial begin : ref_gen
    int cnt;
    cnt = 0;
    forever begin
      @(posedge CLKI_OSC);
      if (ref_half == 0) begin
        ref_clk_i <= 1'b0;                         // held low
        cnt = 0;
      end else if (cnt >= ref_half - 1) begin
        ref_clk_i <= ~ref_clk_i;
        cnt = 0;
      end else begin
        cnt = cnt + 1;
      end
    end
  end

  function automatic int next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return int'(rand_state[30:16]);                // upper bits, better spread
  endfunction

  // loop filter rule, fine or coarse step, or a clamp hit
  function automatic logic step_ok(input delay_t old_d, input delay_t new_d);
    int d;
    d = (new_d > old_d) ? int'(new_d) - int'(old_d) : int'(old_d) - int'(new_d);
    return (d inside {1, 2, 3, 5, 9, 20}) || (new_d == '0) || (new_d == DELAY_MAX);
  endfunction

  // ----------------------------------------------------------------------
  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, expected %0d, got %0d", $time, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t ns: %s never happened", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "wait timed out");
  endtask

  // 3 cycles of reset, optional load on the first active edge
  task automatic apply_reset(input logic with_load, input delay_t base);
    @(posedge CLKI_OSC);
    clk_fbk_f_rst <= 1'b1;
    load_base_i   <= with_load;
    base_dly_i    <= base;
    repeat (3) @(posedge CLKI_OSC);
    clk_fbk_f_rst <= 1'b0;
    @(posedge CLKI_OSC);                           // load sampled here
    load_base_i   <= 1'b0;
    @(negedge CLKI_OSC);
  endtask

  task automatic load_code(input delay_t code);
    @(posedge CLKI_OSC);
    load_base_i <= 1'b1;
    base_dly_i  <= code;
    @(posedge CLKI_OSC);
    load_base_i <= 1'b0;
    @(negedge CLKI_OSC);                           // code visible from here
  endtask

  task automatic set_ref_half(input int h);
    @(negedge CLKI_OSC);
    ref_half = h;
  endtask

  task automatic wait_gen(input logic level, input int limit);
    int n;
    n = 0;
    while (gen_clk_o !== level) begin
      @(negedge CLKI_OSC);
      n++;
      if (n > limit) timed_out("gen_clk_o edge");
    end
  endtask

  // cycles gen_clk_o stays at level, ends on the opposite level
  task automatic measure_half(input logic level, output int cycles);
    cycles = 0;
    while (gen_clk_o === level) begin
      cycles++;
      @(negedge CLKI_OSC);
      if (cycles > 300) timed_out("gen_clk_o toggle");
    end
  endtask

  task automatic wait_lock(input logic level, input int limit);
    int n;
    n = 0;
    while (lock_o !== level) begin
      @(negedge CLKI_OSC);
      n++;
      if (n > limit) timed_out("lock_o change");
    end
  endtask

  // every delay change in closed loop must be a legal step
  always @(negedge CLKI_OSC) begin
    if (mon_steps && (cur_delay_o !== prev_delay)) begin
      check_eq(step_ok(prev_delay, cur_delay_o), 1, "delay step size");
    end
    prev_delay = cur_delay_o;
  end

  // ----------------------------------------------------------------------
  initial begin : main
    int     tgt;
    int     tgt2;
    int     hi;
    int     lo;
    delay_t code;

    ref_half      = 0;
    mon_steps     = 1'b0;
    rand_state    = 32'd94;
    clk_fbk_f_rst = 1'b1;
    ref_clk_i     = 1'b0;
    load_base_i   = 1'b0;
    base_dly_i    = '0;

    // reset values, ref low
    apply_reset(1'b0, '0);
    check_eq(cur_delay_o, DELAY_RESET, "delay after reset");
    check_eq(lock_o, 0, "lock after reset");
    check_eq(gen_clk_o, 0, "gen_clk after reset");

    // base load sticks, no measurement without ref
    code = delay_t'(next_rand() % 128);
    load_code(code);
    check_eq(cur_delay_o, code, "delay one cycle after load");
    repeat (200) begin
      @(negedge CLKI_OSC);
      check_eq(cur_delay_o, code, "delay held without ref");
    end

    // half periods, ring starts clean from reset
    code = delay_t'(next_rand() % 128);
    apply_reset(1'b1, code);
    check_eq(cur_delay_o, code, "delay loaded at reset release");
    repeat (2) begin
      wait_gen(1'b0, 300);
      wait_gen(1'b1, 300);
    end
    repeat (2) begin
      measure_half(1'b1, hi);
      measure_half(1'b0, lo);
      check_eq(hi, int'(code) + 1, "gen_clk high time");
      check_eq(lo, int'(code) + 1, "gen_clk low time");
    end

    // top clamp, long ref keeps pushing up
    load_code(DELAY_MAX);
    set_ref_half(1000);
    repeat (8000) begin
      @(negedge CLKI_OSC);
      check_eq(cur_delay_o, DELAY_MAX, "delay pinned at top");
      check_eq(lock_o, 0, "lock with long ref");
    end

    // bottom clamp, short ref keeps pushing down
    set_ref_half(2);
    repeat (40) @(negedge CLKI_OSC);               // let the short period settle
    load_code('0);
    repeat (100) begin
      @(negedge CLKI_OSC);
      check_eq(cur_delay_o, 0, "delay pinned at bottom");
      check_eq(lock_o, 0, "lock with short ref");
    end

    // closed loop, converges from the top, ref period 10*(T+1)
    set_ref_half(0);
    apply_reset(1'b1, DELAY_MAX);
    tgt = 30 + next_rand() % 81;
    set_ref_half(5 * (tgt + 1));
    mon_steps = 1'b1;
    wait_lock(1'b1, 300000);
    check_eq(cur_delay_o, tgt, "delay at lock");

    // retarget lower, lock drops and comes back
    tgt2 = 20 + next_rand() % (tgt - 25);
    set_ref_half(5 * (tgt2 + 1));
    wait_lock(1'b0, 20000);
    wait_lock(1'b1, 300000);
    check_eq(cur_delay_o, tgt2, "delay at relock");
    mon_steps = 1'b0;

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
